// ==== common/rename_cfg_pkg.sv ====
package rename_cfg_pkg;

  // --------------------------------------------------
  // Group widths
  // --------------------------------------------------

  // Dispatch and retire width
  localparam int lanes = 2;

  // --------------------------------------------------
  // Register file sizing
  // --------------------------------------------------

  // Physical and architectural register counts
  localparam int pr_count   = 64;
  localparam int arch_count = 32;

  // Tag and index widths
  localparam int pr_w   = 6;
  localparam int arch_w = 5;

  // Free count spans 0..pr_count, per-group slots span 0..lanes
  localparam int cnt_w  = 7;
  localparam int slot_w = 2;

  // Tags below this one start out mapped
  localparam int start_tag = arch_count;

endpackage

// ==== common/rename_types_pkg.sv ====
package rename_types_pkg;

  import rename_cfg_pkg::*;

  // Physical register tag
  typedef logic [pr_w-1:0] phys_tag_t;

  // Architectural register index
  typedef logic [arch_w-1:0] arch_idx_t;

  // One instruction of a dispatch group
  typedef struct packed {
    arch_idx_t src1;
    arch_idx_t src2;
    arch_idx_t dest;
    logic      writes_dest;
  } rename_req_t;

  // Rename result for one lane
  typedef struct packed {
    phys_tag_t src1_tag;
    phys_tag_t src2_tag;
    phys_tag_t dest_tag;
    phys_tag_t old_tag;
  } rename_rsp_t;

  // Whole dispatch group with its valid lanes
  typedef struct packed {
    rename_req_t [lanes-1:0] req;
    logic [lanes-1:0]        lane_mask;
  } rename_group_t;

endpackage

// ==== common/retire_if.sv ====
`timescale 1ns/10ps

interface retire_if import rename_cfg_pkg::*, rename_types_pkg::*; ();

  // Lanes committing this cycle
  logic [lanes-1:0] en;

  // Committed destination and its new mapping
  arch_idx_t [lanes-1:0] arch;
  phys_tag_t [lanes-1:0] new_tag;

  // Previous mapping that goes back to the free set
  phys_tag_t [lanes-1:0] old_tag;

  // Driven from the retire ports
  modport source (output en, output arch, output new_tag, output old_tag);

  // Committed map update
  modport map (input en, input arch, input new_tag);

  // Freelist return path
  modport reclaim (input en, input old_tag);

endinterface

// ==== freelist/freelist.sv ====
`timescale 1ns/10ps

module freelist import rename_cfg_pkg::*, rename_types_pkg::*; (
  input  logic                             clock,
  input  logic                             reset_n,

  // Dispatch side
  input  logic [lanes-1:0]                 alloc_mask,
  output phys_tag_t [lanes-1:0]            free_tag,
  output logic [slot_w-1:0]                free_slots,
  output logic [cnt_w-1:0]                 free_count,

  // Retire side
  retire_if.reclaim                        rcl,

  // Recovery
  input  logic                             recover,
  input  phys_tag_t [arch_count-1:0]       arch_map
);

  // One bit per physical register, 1 means free
  logic [pr_count-1:0] free_bm;

  // Offers for this cycle
  phys_tag_t [lanes-1:0] offer;
  logic [lanes-1:0]      offer_ok;

  // Update masks and next state
  logic [pr_count-1:0] set_mask;
  logic [pr_count-1:0] clr_mask;
  logic [pr_count-1:0] held;
  logic [pr_count-1:0] next_bm;

  // --------------------------------------------------
  // Lowest-first scan
  // --------------------------------------------------
  always_comb begin
    logic [pr_count-1:0] scan_bm;
    scan_bm  = free_bm;
    offer_ok = '0;
    for (int i = 0; i < lanes; i++) begin
      offer[i] = '0;
      // Tag 0 is never handed out
      for (int p = 1; p < pr_count; p++) begin
        if (scan_bm[p] && !offer_ok[i]) begin
          offer[i]    = phys_tag_t'(p);
          offer_ok[i] = 1'b1;
          scan_bm[p]  = 1'b0;
        end
      end
    end
  end

  assign free_tag = offer;

  // --------------------------------------------------
  // Counters
  // --------------------------------------------------
  always_comb begin
    free_count = '0;
    for (int p = 0; p < pr_count; p++) begin
      free_count = free_count + cnt_w'(free_bm[p]);
    end
  end

  // Clamp to the group width
  assign free_slots = (free_count >= cnt_w'(lanes)) ? slot_w'(lanes)
                                                    : free_count[slot_w-1:0];

  // --------------------------------------------------
  // Next bitmap
  // --------------------------------------------------
  always_comb begin
    int take_n;
    take_n = 0;
    for (int k = 0; k < lanes; k++) begin
      take_n = take_n + int'(alloc_mask[k]);
    end

    // Retired old tags come back
    set_mask = '0;
    for (int k = 0; k < lanes; k++) begin
      if (rcl.en[k]) set_mask[rcl.old_tag[k]] = 1'b1;
    end

    // Consumed offers leave, always from the bottom of the offer list
    clr_mask = '0;
    for (int k = 0; k < lanes; k++) begin
      if (k < take_n && offer_ok[k]) clr_mask[offer[k]] = 1'b1;
    end

    // Tags held by the committed image, tag 0 included
    held    = '0;
    held[0] = 1'b1;
    for (int r = 0; r < arch_count; r++) begin
      held[arch_map[r]] = 1'b1;
    end

    // Recover wins over both allocate and reclaim
    if (recover) begin
      next_bm = ~held;
    end else begin
      next_bm = (free_bm | set_mask) & ~clr_mask;
    end
    next_bm[0] = 1'b0;
  end

  // --------------------------------------------------
  // State
  // --------------------------------------------------
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      // Identity map owns the low tags
      free_bm <= {pr_count{1'b1}} << start_tag;
    end else begin
      free_bm <= next_bm;
    end
  end

endmodule

// ==== logic/spec_map_table.sv ====
`timescale 1ns/10ps

module spec_map_table import rename_cfg_pkg::*, rename_types_pkg::*; (
  input  logic                             clock,
  input  logic                             reset_n,

  // Dispatch input
  input  logic                             in_valid,
  input  rename_group_t                    in_req,
  output logic                             in_ready,

  // Rename output register
  output logic                             out_valid,
  output rename_rsp_t [lanes-1:0]          out_rsp,
  output logic [lanes-1:0]                 out_mask,
  input  logic                             out_ready,

  // Freelist
  input  phys_tag_t [lanes-1:0]            free_tag,
  input  logic [slot_w-1:0]                free_slots,
  output logic [lanes-1:0]                 alloc_mask,

  // Recovery
  input  logic                             recover,
  input  phys_tag_t [arch_count-1:0]       arch_map
);

  // Speculative arch to phys map
  phys_tag_t [arch_count-1:0] spec_map;

  // Lanes that need a new tag
  logic [lanes-1:0]        need;
  logic [slot_w-1:0]       demand;
  rename_rsp_t [lanes-1:0] rsp;

  // Handshake terms
  logic run_q;
  logic drain;
  logic accept;

  // --------------------------------------------------
  // Lookup, tag pick and forwarding
  // --------------------------------------------------
  always_comb begin
    int        slot;
    phys_tag_t pick;
    slot   = 0;
    demand = '0;
    for (int i = 0; i < lanes; i++) begin
      // Register 0 never renames
      need[i] = in_req.lane_mask[i] && in_req.req[i].writes_dest
                && (in_req.req[i].dest != '0);

      // Next free tag in order
      pick = '0;
      for (int k = 0; k < lanes; k++) begin
        if (k == slot) pick = free_tag[k];
      end

      rsp[i].src1_tag = spec_map[in_req.req[i].src1];
      rsp[i].src2_tag = spec_map[in_req.req[i].src2];
      rsp[i].dest_tag = need[i] ? pick : '0;
      rsp[i].old_tag  = need[i] ? spec_map[in_req.req[i].dest] : '0;

      // Older lanes in the group override the table, latest writer wins
      for (int j = 0; j < i; j++) begin
        if (need[j] && in_req.req[j].dest == in_req.req[i].src1)
          rsp[i].src1_tag = rsp[j].dest_tag;
        if (need[j] && in_req.req[j].dest == in_req.req[i].src2)
          rsp[i].src2_tag = rsp[j].dest_tag;
        if (need[i] && need[j] && in_req.req[j].dest == in_req.req[i].dest)
          rsp[i].old_tag = rsp[j].dest_tag;
      end

      if (need[i]) begin
        slot   = slot + 1;
        demand = demand + slot_w'(1);
      end
    end
  end

  // --------------------------------------------------
  // Handshake
  // --------------------------------------------------

  // Output register free now or at this edge
  assign drain = !out_valid || out_ready;

  // Whole group or nothing
  assign in_ready = run_q && !recover && drain && (demand <= free_slots);
  assign accept   = in_valid && in_ready;

  // Freelist consumes from its lowest offer
  assign alloc_mask = accept ? need : '0;

  // Ready comes up one edge after reset release
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  // --------------------------------------------------
  // Speculative map
  // --------------------------------------------------
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int r = 0; r < arch_count; r++) begin
        spec_map[r] <= phys_tag_t'(r);
      end
    end else if (recover) begin
      spec_map <= arch_map;
    end else if (accept) begin
      // Higher lane lands last
      for (int i = 0; i < lanes; i++) begin
        if (need[i]) spec_map[in_req.req[i].dest] <= rsp[i].dest_tag;
      end
    end
  end

  // --------------------------------------------------
  // Output register
  // --------------------------------------------------
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      out_valid <= 1'b0;
    end else if (recover) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // Payload held while stalled
  always_ff @(posedge clock) begin
    if (accept) begin
      out_rsp  <= rsp;
      out_mask <= in_req.lane_mask;
    end
  end

endmodule

// ==== logic/arch_map_table.sv ====
`timescale 1ns/10ps

module arch_map_table import rename_cfg_pkg::*, rename_types_pkg::*; (
  input  logic                             clock,
  input  logic                             reset_n,

  // Retire commits
  retire_if.map                            rt,

  // Committed image for recovery and freelist rebuild
  output phys_tag_t [arch_count-1:0]       arch_map
);

  // --------------------------------------------------
  // Committed map
  // --------------------------------------------------

  // Identity after reset
  // Entry 0 stays on tag 0 for good
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int r = 0; r < arch_count; r++) begin
        arch_map[r] <= phys_tag_t'(r);
      end
    end else begin
      // Lane order, the younger commit lands last
      for (int i = 0; i < lanes; i++) begin
        if (rt.en[i] && (rt.arch[i] != '0)) begin
          arch_map[rt.arch[i]] <= rt.new_tag[i];
        end
      end
    end
  end

endmodule

// ==== logic/rename_unit.sv ====
`timescale 1ns/10ps

module rename_unit import rename_cfg_pkg::*, rename_types_pkg::*; (
  input  logic                             clock,
  input  logic                             reset_n,

  // Dispatch group
  input  logic                             in_valid,
  input  rename_group_t                    in_req,
  output logic                             in_ready,

  // Rename results
  output logic                             out_valid,
  output rename_rsp_t [lanes-1:0]          out_rsp,
  output logic [lanes-1:0]                 out_mask,
  input  logic                             out_ready,

  // Retire commands
  input  logic [lanes-1:0]                 retire_en,
  input  arch_idx_t [lanes-1:0]            retire_arch,
  input  phys_tag_t [lanes-1:0]            retire_new_tag,
  input  phys_tag_t [lanes-1:0]            retire_old_tag,

  // Recovery pulse
  input  logic                             recover,

  // Free tags left
  output logic [cnt_w-1:0]                 free_count
);

  // --------------------------------------------------
  // Internal nets
  // --------------------------------------------------
  phys_tag_t [lanes-1:0]      free_tag;
  logic [slot_w-1:0]          free_slots;
  logic [lanes-1:0]           alloc_mask;
  phys_tag_t [arch_count-1:0] arch_map;

  // Retire bus fed from the ports
  retire_if rt_bus ();

  assign rt_bus.en      = retire_en;
  assign rt_bus.arch    = retire_arch;
  assign rt_bus.new_tag = retire_new_tag;
  assign rt_bus.old_tag = retire_old_tag;

  // --------------------------------------------------
  // Blocks
  // --------------------------------------------------
  freelist freelist_inst (
    .clock      (clock),
    .reset_n    (reset_n),
    .alloc_mask (alloc_mask),
    .free_tag   (free_tag),
    .free_slots (free_slots),
    .free_count (free_count),
    .rcl        (rt_bus.reclaim),
    .recover    (recover),
    .arch_map   (arch_map)
  );

  spec_map_table spec_map_table_inst (
    .clock      (clock),
    .reset_n    (reset_n),
    .in_valid   (in_valid),
    .in_req     (in_req),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_rsp    (out_rsp),
    .out_mask   (out_mask),
    .out_ready  (out_ready),
    .free_tag   (free_tag),
    .free_slots (free_slots),
    .alloc_mask (alloc_mask),
    .recover    (recover),
    .arch_map   (arch_map)
  );

  arch_map_table arch_map_table_inst (
    .clock    (clock),
    .reset_n  (reset_n),
    .rt       (rt_bus.map),
    .arch_map (arch_map)
  );

endmodule

// ==== sim/clock_gen.sv ====
`timescale 1ns/10ps

module clock_gen #(
  parameter real period_ns    = 8.0,
  parameter int  reset_cycles = 8
) (
  output logic clock,
  output logic reset_n
);

  // Free running clock, low half first
  initial begin
    clock = 1'b0;
    forever #(period_ns / 2.0) clock = ~clock;
  end

  // Reset held low, released on a rising edge
  initial begin
    reset_n = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    reset_n <= 1'b1;
  end

endmodule

// ==== sim/rename_unit_tb.sv ====
`timescale 1ns/10ps

module rename_unit_tb import rename_cfg_pkg::*, rename_types_pkg::*; ();

  localparam logic [31:0] seed       = 32'hefdb3bfa;
  localparam int          run_cycles = 4000;
  localparam int          hold_limit = 64;
  localparam int          rst_limit  = 64;

  logic                       clock;
  logic                       reset_n;
  logic                       in_valid;
  rename_group_t              in_req;
  logic                       in_ready;
  logic                       out_valid;
  rename_rsp_t [lanes-1:0]    out_rsp;
  logic [lanes-1:0]           out_mask;
  logic                       out_ready;
  logic [lanes-1:0]           retire_en;
  arch_idx_t [lanes-1:0]      retire_arch;
  phys_tag_t [lanes-1:0]      retire_new_tag;
  phys_tag_t [lanes-1:0]      retire_old_tag;
  logic                       recover;
  logic [cnt_w-1:0]           free_count;

  // Reference model state
  logic [pr_count-1:0]        m_free;
  phys_tag_t [arch_count-1:0] m_spec;
  phys_tag_t [arch_count-1:0] m_arch;

  // Expected contents of the output register
  rename_rsp_t [lanes-1:0]    held_rsp;
  logic [lanes-1:0]           held_need;
  logic [lanes-1:0]           held_mask;

  // One-cycle event flags
  logic fresh_q;
  logic accepted_q;
  logic recovered_q;

  // Retire and recover held back until a group runs short of free tags
  logic starve;

  logic [31:0] lfsr_state;
  logic [arch_w+2*pr_w-1:0] retire_q[$];
  int hold_n;

  clock_gen clock_gen_inst (.clock(clock), .reset_n(reset_n));

  rename_unit rename_unit_inst (
    .clock(clock), .reset_n(reset_n),
    .in_valid(in_valid), .in_req(in_req), .in_ready(in_ready),
    .out_valid(out_valid), .out_rsp(out_rsp), .out_mask(out_mask), .out_ready(out_ready),
    .retire_en(retire_en), .retire_arch(retire_arch),
    .retire_new_tag(retire_new_tag), .retire_old_tag(retire_old_tag),
    .recover(recover), .free_count(free_count)
  );

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  task automatic report_error(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    $display("TB FAILED");
    $fatal(1, "Check failed");
  endtask

  task automatic report_timeout(input string msg);
    $display("Timeout: %s", msg);
    $display("TB FAILED");
    $fatal(1, "Timeout");
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [cnt_w-1:0] count_ones(input logic [pr_count-1:0] bm);
    logic [cnt_w-1:0] c;
    c = '0;
    for (int p = 0; p < pr_count; p++) c = c + cnt_w'(bm[p]);
    return c;
  endfunction

  function automatic logic needs_tag(input rename_group_t g, input int i);
    return g.lane_mask[i] && g.req[i].writes_dest && (g.req[i].dest != '0);
  endfunction

  function automatic int group_demand(input rename_group_t g);
    int d;
    d = 0;
    for (int i = 0; i < lanes; i++) d = d + int'(needs_tag(g, i));
    return d;
  endfunction

  function automatic int slots_left(input logic [pr_count-1:0] bm);
    int c;
    c = int'(count_ones(bm));
    return (c < lanes) ? c : lanes;
  endfunction

  // Small register range half the time so lanes collide often
  function automatic arch_idx_t pick_reg();
    if (take_bits(1) != 0) return arch_idx_t'(take_bits(3));
    return arch_idx_t'(take_bits(5));
  endfunction

  function automatic rename_group_t random_group();
    rename_group_t g;
    for (int i = 0; i < lanes; i++) begin
      g.req[i].src1        = pick_reg();
      g.req[i].src2        = pick_reg();
      g.req[i].dest        = pick_reg();
      g.req[i].writes_dest = (take_bits(2) != 0);
    end
    g.lane_mask = lanes'(take_bits(2));
    if (g.lane_mask == '0) g.lane_mask = 2'b01;
    return g;
  endfunction

  // Model rename of one group with lowest free tags in lane order
  task automatic predict_group(input rename_group_t g, output rename_rsp_t [lanes-1:0] rsp,
                               output logic [lanes-1:0] need);
    logic [pr_count-1:0] pool;
    pool = m_free;
    for (int i = 0; i < lanes; i++) begin
      need[i] = needs_tag(g, i);
      rsp[i].src1_tag = m_spec[g.req[i].src1];
      rsp[i].src2_tag = m_spec[g.req[i].src2];
      rsp[i].old_tag  = m_spec[g.req[i].dest];
      rsp[i].dest_tag = '0;
      if (need[i]) begin
        for (int p = pr_count - 1; p > 0; p--) begin
          if (pool[p]) rsp[i].dest_tag = phys_tag_t'(p);
        end
        pool[rsp[i].dest_tag] = 1'b0;
      end
    end
    // Lane 1 sees lane 0's new mapping
    if (need[0]) begin
      if (g.req[0].dest == g.req[1].src1) rsp[1].src1_tag = rsp[0].dest_tag;
      if (g.req[0].dest == g.req[1].src2) rsp[1].src2_tag = rsp[0].dest_tag;
      if (g.req[0].dest == g.req[1].dest) rsp[1].old_tag = rsp[0].dest_tag;
    end
  endtask

  function automatic logic rsp_ok(input rename_rsp_t [lanes-1:0] got,
                                  input rename_rsp_t [lanes-1:0] want,
                                  input logic [lanes-1:0]        need,
                                  input logic [lanes-1:0]        mask);
    logic ok;
    ok = 1'b1;
    for (int i = 0; i < lanes; i++) begin
      if (mask[i]) begin
        ok = ok && got[i].src1_tag == want[i].src1_tag;
        ok = ok && got[i].src2_tag == want[i].src2_tag;
      end
      if (need[i]) begin
        ok = ok && got[i].dest_tag == want[i].dest_tag && got[i].dest_tag != '0;
        ok = ok && got[i].old_tag == want[i].old_tag;
      end
    end
    if (need == 2'b11) ok = ok && got[0].dest_tag != got[1].dest_tag;
    return ok;
  endfunction

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  a_reset_count: assert property (@(posedge clock) disable iff (!reset_n)
    fresh_q |-> free_count == cnt_w'(start_tag))
    else report_error($sformatf("free_count %0d after reset", free_count));

  a_free_count: assert property (@(posedge clock) disable iff (!reset_n)
    free_count == count_ones(m_free))
    else report_error($sformatf("free_count %0d, model %0d", free_count, count_ones(m_free)));

  a_out_after_accept: assert property (@(posedge clock) disable iff (!reset_n)
    accepted_q |-> out_valid)
    else report_error("out_valid low one cycle after accept");

  a_out_payload: assert property (@(posedge clock) disable iff (!reset_n)
    out_valid |-> (rsp_ok(out_rsp, held_rsp, held_need, held_mask) && out_mask == held_mask))
    else report_error($sformatf("out_rsp %h differs from model %h", out_rsp, held_rsp));

  a_stall_ready: assert property (@(posedge clock) disable iff (!reset_n)
    (out_valid && !out_ready) |-> !in_ready)
    else report_error("in_ready high while output is stalled");

  a_demand_ready: assert property (@(posedge clock) disable iff (!reset_n)
    (group_demand(in_req) > slots_left(m_free)) |-> !in_ready)
    else report_error("in_ready high with too few free tags");

  a_recover_ready: assert property (@(posedge clock) disable iff (!reset_n)
    recover |-> !in_ready)
    else report_error("in_ready high during recover");

  a_recover_state: assert property (@(posedge clock) disable iff (!reset_n)
    recovered_q |-> (free_count == cnt_w'(pr_count - arch_count) && !out_valid))
    else report_error($sformatf("free_count %0d after recover", free_count));

  // --------------------------------------------------
  // Model update from the handshakes seen at this edge
  // --------------------------------------------------
  task automatic observe_edge();
    logic [pr_count-1:0]        nf;
    phys_tag_t [arch_count-1:0] ns;
    phys_tag_t [arch_count-1:0] na;
    logic [pr_count-1:0]        held;
    rename_rsp_t [lanes-1:0]    rsp;
    logic [lanes-1:0]           need;
    nf = m_free;
    ns = m_spec;
    na = m_arch;
    fresh_q     <= 1'b0;
    accepted_q  <= 1'b0;
    recovered_q <= 1'b0;
    if (recover) begin
      held    = '0;
      held[0] = 1'b1;
      for (int r = 0; r < arch_count; r++) held[m_arch[r]] = 1'b1;
      nf = ~held;
      ns = m_arch;
      // Squashed groups never retire
      retire_q.delete();
      recovered_q <= 1'b1;
    end else begin
      for (int k = 0; k < lanes; k++) begin
        if (retire_en[k]) nf[retire_old_tag[k]] = 1'b1;
      end
      if (in_valid && in_ready) begin
        predict_group(in_req, rsp, need);
        for (int i = 0; i < lanes; i++) begin
          if (need[i]) begin
            nf[rsp[i].dest_tag] = 1'b0;
            ns[in_req.req[i].dest] = rsp[i].dest_tag;
            retire_q.push_back({in_req.req[i].dest, rsp[i].dest_tag, rsp[i].old_tag});
          end
        end
        held_rsp   <= rsp;
        held_need  <= need;
        held_mask  <= in_req.lane_mask;
        accepted_q <= 1'b1;
      end
    end
    for (int k = 0; k < lanes; k++) begin
      if (retire_en[k] && retire_arch[k] != '0) na[retire_arch[k]] = retire_new_tag[k];
    end
    m_free <= nf;
    m_spec <= ns;
    m_arch <= na;
  endtask

  // Next cycle's inputs
  task automatic drive_next(input logic acc);
    logic [lanes-1:0] en;
    arch_idx_t [lanes-1:0] ra;
    phys_tag_t [lanes-1:0] rn;
    phys_tag_t [lanes-1:0] ro;
    logic [arch_w+2*pr_w-1:0] e;
    int n;
    en = '0;
    ra = '0;
    rn = '0;
    ro = '0;
    if (acc || !in_valid) begin
      hold_n = 0;
      if (take_bits(2) != 0) begin
        in_valid <= 1'b1;
        in_req   <= random_group();
      end else begin
        in_valid <= 1'b0;
      end
    end else begin
      hold_n++;
      if (hold_n > hold_limit) report_timeout("dispatch group was never accepted");
    end
    out_ready <= (take_bits(2) != 0);
    if (!starve && take_bits(7) == 0) begin
      recover <= 1'b1;
    end else begin
      recover <= 1'b0;
      if (!starve && retire_q.size() > 0 && take_bits(1) != 0) begin
        n = 1 + int'(take_bits(1));
        for (int k = 0; k < n; k++) begin
          if (retire_q.size() > 0) begin
            e = retire_q.pop_front();
            en[k] = 1'b1;
            {ra[k], rn[k], ro[k]} = e;
          end
        end
      end
    end
    retire_en      <= en;
    retire_arch    <= ra;
    retire_new_tag <= rn;
    retire_old_tag <= ro;
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    int n;
    logic acc;
    in_valid       = 1'b0;
    in_req         = '0;
    out_ready      = 1'b0;
    retire_en      = '0;
    retire_arch    = '0;
    retire_new_tag = '0;
    retire_old_tag = '0;
    recover        = 1'b0;
    lfsr_state     = seed;
    m_free         = {pr_count{1'b1}} << start_tag;
    for (int r = 0; r < arch_count; r++) begin
      m_spec[r] = phys_tag_t'(r);
      m_arch[r] = phys_tag_t'(r);
    end
    held_rsp    = '0;
    held_need   = '0;
    held_mask   = '0;
    fresh_q     = 1'b1;
    accepted_q  = 1'b0;
    recovered_q = 1'b0;
    starve      = 1'b0;
    hold_n      = 0;

    n = 0;
    while (reset_n !== 1'b1) begin
      @(posedge clock);
      n++;
      if (n > rst_limit) report_timeout("reset was never released");
    end

    for (int cyc = 0; cyc < run_cycles; cyc++) begin
      @(posedge clock);
      acc = in_valid && in_ready;
      // Now and then let the free tags run out
      if (cyc % 1000 == 500) starve = 1'b1;
      if (starve && in_valid && group_demand(in_req) > slots_left(m_free)) starve = 1'b0;
      observe_edge();
      drive_next(acc);
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== rename_unit.f ====
common/rename_cfg_pkg.sv
common/rename_types_pkg.sv
common/retire_if.sv
freelist/freelist.sv
logic/spec_map_table.sv
logic/arch_map_table.sv
logic/rename_unit.sv
sim/clock_gen.sv
sim/rename_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rename unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rename_unit_tb \
  -f rename_unit.f --Mdir obj_dir -o rename_unit_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/rename_unit_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q '^TB PASSED$'; then
  exit 0
fi
exit 1
